// File: compile.f
+incdir+tests
src/mipsPkg.sv
src/alu.sv
src/registerFile.sv
src/controlUnit.sv
src/datapath.sv
src/mipsProcessor.sv
tests/mipsProcessor_properties.sv
tests/mipsProcessor_tb.sv

// File: Bender.yml
package:
  name: mips_processor

sources:
  - src/mipsPkg.sv
  - src/alu.sv
  - src/registerFile.sv
  - src/controlUnit.sv
  - src/datapath.sv
  - src/mipsProcessor.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/mipsProcessor_properties.sv
      - tests/mipsProcessor_tb.sv

// File: tests/mipsTests.svh
`ifndef MIPS_TESTS_SVH
`define MIPS_TESTS_SVH

task automatic checkWord(string name, word_t got, word_t expected);
	if (got !== expected)
		stopOnError($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expected));
endtask

task automatic checkAddr(string name, memAddr_t got, memAddr_t expected);
	if (got !== expected)
		stopOnError($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expected));
endtask

// Straight-line code, so every read is a fetch
task automatic fetchOrder();
	prog.delete();
	emit(iType(OpAddiu, 5'd1, 5'd0, 16'h0001));
	emit(iType(OpAddiu, 5'd2, 5'd1, 16'h0002));
	emit(rType(FnAddu, 5'd3, 5'd1, 5'd2));
	emit(iType(OpOri, 5'd4, 5'd3, 16'h00F0));
	runProgram();
	if (reqLog.size() != prog.size() + 1)
		stopOnError($sformatf("Expected %0d memory requests but saw %0d",
			prog.size() + 1, reqLog.size()));
	for (int i = 0; i < prog.size(); i++) begin
		if (!reqLog[i].read || reqLog[i].write)
			stopOnError($sformatf("Fetch request %0d was not a plain read", i));
		checkAddr($sformatf("fetch[%0d].addr", i), reqLog[i].addr, memAddr_t'(4 * i));
	end
	checkAddr("marker.addr", reqLog[prog.size()].addr, MARKER_ADDR);
endtask

// A = 0x12345685 (shift 5), B = 0xF0F01234 (negative)
task automatic rTypeOps();
	funct_e fns[11] = '{FnAddu, FnSubu, FnAnd, FnOr, FnXor, FnNor,
		FnSlt, FnSltu, FnSllv, FnSrlv, FnSrav};
	word_t expected[11] = '{32'h0324_68B9, 32'h2144_4451, 32'h1030_1204,
		32'hF2F4_56B5, 32'hE2C4_44B1, 32'h0D0B_A94A, 32'h0000_0000,
		32'h0000_0001, 32'h1E02_4680, 32'h0787_8091, 32'hFF87_8091};
	prog.delete();
	loadConst(5'd1, 32'h1234_5685);
	loadConst(5'd2, 32'hF0F0_1234);
	for (int i = 0; i < 11; i++)
		emit(rType(fns[i], regAddr_t'(3 + i), 5'd1, 5'd2));
	for (int i = 0; i < 11; i++)
		emit(iType(OpSw, regAddr_t'(3 + i), 5'd0, 16'(DATA_BASE + 4 * i)));
	runProgram();
	for (int i = 0; i < 11; i++)
		checkWord($sformatf("rtype %s", fns[i].name()),
			readWord(memAddr_t'(DATA_BASE + 4 * i)), expected[i]);
endtask

// Sign extension for ADDIU/SLTI/SLTIU, zero extension for logic ops
task automatic iTypeOps();
	opcode_e ops[8] = '{OpAddiu, OpSlti, OpSltiu, OpSlti, OpAndi, OpOri, OpXori, OpLui};
	regAddr_t srcs[8] = '{5'd1, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1, 5'd2, 5'd0};
	logic [15:0] imms[8] = '{16'hFFFE, 16'hFFF8, 16'hFFF8, 16'hFFF8,
		16'h8F0F, 16'h8001, 16'hFFFF, 16'h8001};
	word_t expected[8] = '{32'h1234_5683, 32'h0000_0000, 32'h0000_0001,
		32'h0000_0001, 32'h0000_8F00, 32'h1234_D685, 32'hFFFF_000F, 32'h8001_0000};
	prog.delete();
	loadConst(5'd1, 32'h1234_5685);
	loadConst(5'd2, 32'hFFFF_FFF0);  // -16
	for (int i = 0; i < 8; i++)
		emit(iType(ops[i], regAddr_t'(3 + i), srcs[i], imms[i]));
	for (int i = 0; i < 8; i++)
		emit(iType(OpSw, regAddr_t'(3 + i), 5'd0, 16'(DATA_BASE + 4 * i)));
	runProgram();
	for (int i = 0; i < 8; i++)
		checkWord($sformatf("itype[%0d] %s", i, ops[i].name()),
			readWord(memAddr_t'(DATA_BASE + 4 * i)), expected[i]);
endtask

task automatic loadStore();
	memAddr_t addrs[6] = '{9'h180, 9'h1A4, 9'h1C0, 9'h1C4, 9'h1C8, 9'h1CC};
	word_t expected[6] = '{32'h5A5A_C3C3, 32'h0F1E_2D3C, 32'h5A5A_C3C3,
		32'h0F1E_2D3C, 32'h0000_0000, 32'h0000_0000};
	prog.delete();
	loadConst(5'd1, 32'h5A5A_C3C3);
	loadConst(5'd2, 32'h0F1E_2D3C);
	emit(iType(OpAddiu, 5'd3, 5'd0, 16'h0100));  // Base register
	emit(iType(OpSw, 5'd1, 5'd0, 16'h0180));
	emit(iType(OpSw, 5'd2, 5'd3, 16'h00A4));
	emit(iType(OpLw, 5'd4, 5'd0, 16'h0180));
	emit(iType(OpLw, 5'd5, 5'd3, 16'h00A4));
	emit(iType(OpSw, 5'd4, 5'd0, 16'h01C0));
	emit(iType(OpSw, 5'd5, 5'd0, 16'h01C4));
	emit(iType(OpAddiu, 5'd0, 5'd1, 16'h0000));  // ALU write to $zero
	emit(iType(OpSw, 5'd0, 5'd0, 16'h01C8));
	emit(iType(OpLw, 5'd0, 5'd0, 16'h0180));     // Load into $zero
	emit(iType(OpSw, 5'd0, 5'd0, 16'h01CC));
	runProgram();
	for (int i = 0; i < 6; i++)
		checkWord($sformatf("mem[0x%h]", addrs[i]), readWord(addrs[i]), expected[i]);
endtask

// Same programs with moc after 1 to 4 cycles
task automatic randomDelays();
	randomDelay = 1'b1;
	fetchOrder();
	rTypeOps();
	iTypeOps();
	loadStore();
endtask

`endif

// File: tests/mipsProcessor_tb.sv
`timescale 1ns/1ps

module mipsProcessor_tb;
	import mipsPkg::*;

	localparam int       MEM_BYTES      = 2 ** ADDR_W;
	localparam int       RESET_CYCLES   = 10;
	localparam int       MARKER_TIMEOUT = 3000;  // Cycles allowed per program
	localparam int       WATCHDOG       = 80000;
	localparam int       PAD_NOPS       = 3;
	localparam memAddr_t DATA_BASE      = 9'h180;  // Results land here
	localparam memAddr_t MARKER_ADDR    = 9'h1FC;
	localparam word_t    NOP_WORD       = 32'h0000_0000;

	logic    CLK;
	logic    reset;
	memReq_t memReq;
	memRsp_t memRsp;

	logic [7:0] mem [MEM_BYTES];  // Big-endian bytes
	word_t      prog [$];
	memReq_t    reqLog [$];       // Each request as first seen
	logic       randomDelay;
	logic       markerSeen;
	logic       pending;
	int         waitLeft;
	int         seed = 19;

	mipsProcessor dut0 (
		.CLK    (CLK),
		.reset  (reset),
		.memReq (memReq),
		.memRsp (memRsp)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;  // 8 ns period
	end

	// Hard stop for the whole run
	initial begin
		repeat (WATCHDOG) @(posedge CLK);
		$display("Simulation ran out of cycles before the tests completed");
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

	function automatic word_t readWord(memAddr_t addr);
		return {mem[addr], mem[memAddr_t'(addr + 1)], mem[memAddr_t'(addr + 2)],
			mem[memAddr_t'(addr + 3)]};
	endfunction

	task automatic writeWord(memAddr_t addr, word_t data);
		mem[addr]                = data[31:24];  // MSB at lowest address
		mem[memAddr_t'(addr + 1)] = data[23:16];
		mem[memAddr_t'(addr + 2)] = data[15:8];
		mem[memAddr_t'(addr + 3)] = data[7:0];
	endtask

	// Instruction encoders
	function automatic word_t rType(funct_e fn, regAddr_t rd, regAddr_t rs, regAddr_t rt);
		return {OpRType, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t iType(opcode_e op, regAddr_t rt, regAddr_t rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic emit(word_t instr);
		prog.push_back(instr);
	endtask

	// LUI then ORI
	task automatic loadConst(regAddr_t r, word_t value);
		emit(iType(OpLui, r, 5'd0, value[31:16]));
		emit(iType(OpOri, r, r, value[15:0]));
	endtask

	task automatic stopOnError(string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "stopping at first error");
	endtask

	// Abort at the first handshake assertion failure
	always @(posedge CLK) begin
		#2;
		if (dut0.props0.failCount != 0)
			stopOnError("A memory handshake assertion failed");
	end

	// Appends pad and marker, loads memory, resets the core, waits for the marker
	task automatic runProgram();
		int cycles;
		for (int i = 0; i < PAD_NOPS; i++)
			emit(NOP_WORD);
		emit(iType(OpSw, 5'd0, 5'd0, 16'(MARKER_ADDR)));
		@(posedge CLK);
		#1;
		reset = 1'b1;
		for (int a = 0; a < MEM_BYTES; a++)
			mem[a] = 8'(a) ^ {a[8], 7'h2A};  // Fill depends on all 9 address bits
		foreach (prog[i])
			writeWord(memAddr_t'(4 * i), prog[i]);
		reqLog.delete();
		markerSeen = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		reset = 1'b0;
		cycles = 0;
		while (!markerSeen && cycles < MARKER_TIMEOUT) begin
			@(posedge CLK);
			cycles++;
		end
		if (!markerSeen)
			stopOnError("Timed out waiting for the marker store to reach memory");
	endtask

	task automatic serveRequest();
		memRsp.moc = 1'b1;
		if (memReq.read)
			memRsp.rdata = readWord(memReq.addr);
		if (memReq.write) begin
			writeWord(memReq.addr, memReq.wdata);
			if (memReq.addr == MARKER_ADDR)
				markerSeen = 1'b1;
		end
	endtask

	// Memory model answering 1 ns after the edge
	initial begin
		memRsp   = '0;
		pending  = 1'b0;
		waitLeft = 0;
		forever begin
			@(posedge CLK);
			#1;
			memRsp = '0;  // moc lasts one cycle
			if (reset) begin
				pending = 1'b0;
			end else if (pending || memReq.mov) begin
				if (!pending) begin
					pending  = 1'b1;
					waitLeft = randomDelay ? 1 + ($unsigned($random(seed)) % 4) : 1;
					reqLog.push_back(memReq);
				end
				waitLeft--;
				if (waitLeft == 0) begin
					pending = 1'b0;
					serveRequest();
				end
			end
		end
	end

	`include "mipsTests.svh"

	initial begin
		reset       = 1'b1;
		randomDelay = 1'b0;  // Fixed single-cycle moc first
		markerSeen  = 1'b0;
		fetchOrder();
		rTypeOps();
		iTypeOps();
		loadStore();
		randomDelays();
		if (dut0.props0.failCount == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("A memory handshake assertion failed");
			$display("TB FAILED");
			$fatal(1, "handshake assertion failure");
		end
	end

endmodule

// File: tests/mipsProcessor_properties.sv
`timescale 1ns/1ps

module mipsProcessor_properties (
	input logic             CLK,
	input logic             reset,
	input mipsPkg::memReq_t memReq,
	input mipsPkg::memRsp_t memRsp
);
	int failCount = 0;  // Assertion failures so far

	// Request frozen until the moc edge
	property reqHeld;
		@(posedge CLK) disable iff (reset)
			(memReq.mov && !memRsp.moc) |=>
				(memReq.mov && $stable(memReq.read) && $stable(memReq.write) &&
				$stable(memReq.addr) && $stable(memReq.wdata));
	endproperty

	property oneDirection;
		@(posedge CLK) disable iff (reset) !(memReq.read && memReq.write);
	endproperty

	property idleInReset;
		@(posedge CLK) reset |=> !memReq.mov;
	endproperty

	reqHeldA: assert property (reqHeld) else begin
		failCount++;
		$error("memory request changed before moc");
	end

	oneDirectionA: assert property (oneDirection) else begin
		failCount++;
		$error("read and write requested together");
	end

	idleInResetA: assert property (idleInReset) else begin
		failCount++;
		$error("mov high during reset");
	end

endmodule

bind mipsProcessor mipsProcessor_properties props0 (
	.CLK    (CLK),
	.reset  (reset),
	.memReq (memReq),
	.memRsp (memRsp)
);

// File: src/mipsProcessor.sv
`timescale 1ns/1ps

module mipsProcessor (
	input  logic             CLK,
	input  logic             reset,
	output mipsPkg::memReq_t memReq,
	input  mipsPkg::memRsp_t memRsp
);
	import mipsPkg::*;

	ctrlWord_t ctrl;
	opcode_e   instrOpcode;
	funct_e    instrFunct;
	logic      mov;
	logic      memRead;
	logic      memWrite;
	memAddr_t  memAddr;
	word_t     memWdata;

	// Request fields from both halves of the core
	assign memReq = '{mov: mov, read: memRead, write: memWrite,
		addr: memAddr, wdata: memWdata};

	controlUnit cu0 (
		.CLK         (CLK),
		.reset       (reset),
		.instrOpcode (instrOpcode),
		.instrFunct  (instrFunct),
		.moc         (memRsp.moc),
		.mov         (mov),
		.memRead     (memRead),
		.memWrite    (memWrite),
		.ctrl        (ctrl)
	);

	datapath dp0 (
		.CLK         (CLK),
		.reset       (reset),
		.ctrl        (ctrl),
		.memRdata    (memRsp.rdata),
		.memAddr     (memAddr),
		.memWdata    (memWdata),
		.instrOpcode (instrOpcode),
		.instrFunct  (instrFunct)
	);

endmodule

// File: src/datapath.sv
`timescale 1ns/1ps

module datapath (
	input  logic               CLK,
	input  logic               reset,
	input  mipsPkg::ctrlWord_t ctrl,
	input  mipsPkg::word_t     memRdata,
	output mipsPkg::memAddr_t  memAddr,
	output mipsPkg::word_t     memWdata,
	output mipsPkg::opcode_e   instrOpcode,
	output mipsPkg::funct_e    instrFunct
);
	import mipsPkg::*;

	memAddr_t pc;
	memAddr_t mar;
	word_t    ir;
	word_t    regA;
	word_t    regB;
	word_t    aluOut;  // Execute result
	word_t    mdr;     // Load data
	word_t    rfDataA;
	word_t    rfDataB;
	word_t    immExt;
	word_t    aluB;
	word_t    aluY;
	word_t    wrData;
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t rd;
	regAddr_t wrAddr;
	logic     zeroExt;

	// Instruction fields
	assign rs          = ir[25:21];
	assign rt          = ir[20:16];
	assign rd          = ir[15:11];
	assign instrOpcode = opcode_e'(ir[31:26]);
	assign instrFunct  = funct_e'(ir[5:0]);

	// Logical immediates zero-extend, arithmetic and memory sign-extend
	assign zeroExt = (instrOpcode == OpAndi) || (instrOpcode == OpOri) ||
		(instrOpcode == OpXori);
	assign immExt  = zeroExt ? {16'h0000, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};

	// Muxes
	assign aluB    = ctrl.aluSrcImm ? immExt : regB;
	assign wrAddr  = ctrl.regDstRd ? rd : rt;
	assign wrData  = ctrl.regInMem ? mdr : aluOut;
	assign memAddr = ctrl.addrMar ? mar : pc;
	assign memWdata = regB;  // SW data is rt

	// PC and IR
	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= RESET_PC;
			ir <= '0;
		end else begin
			if (ctrl.pcLd)
				pc <= pc + INSTR_BYTES;
			if (ctrl.irLd)
				ir <= memRdata;
		end
	end

	// Operand and result registers
	always_ff @(posedge CLK) begin
		if (ctrl.abLd) begin
			regA <= rfDataA;
			regB <= rfDataB;
		end
		if (ctrl.aluOutLd)
			aluOut <= aluY;
		if (ctrl.marLd)
			mar <= aluY[ADDR_W-1:0];  // Byte address from base + offset
		if (ctrl.mdrLd)
			mdr <= memRdata;
	end

	registerFile rf0 (
		.CLK     (CLK),
		.reset   (reset),
		.rdAddrA (rs),
		.rdAddrB (rt),
		.wrAddr  (wrAddr),
		.wrData  (wrData),
		.wrEn    (ctrl.regWrite),
		.rdDataA (rfDataA),
		.rdDataB (rfDataB)
	);

	alu alu0 (
		.op (ctrl.aluOp),
		.a  (regA),
		.b  (aluB),
		.y  (aluY)
	);

endmodule

// File: src/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input  logic               CLK,
	input  logic               reset,
	input  mipsPkg::opcode_e   instrOpcode,
	input  mipsPkg::funct_e    instrFunct,
	input  logic               moc,
	output logic               mov,
	output logic               memRead,
	output logic               memWrite,
	output mipsPkg::ctrlWord_t ctrl
);
	import mipsPkg::*;

	state_e state, stateNext;
	aluOp_e aluOp;
	logic   isNop;  // Unknown opcode or funct
	logic   isMem;
	logic   isLoad;
	logic   done;   // Transfer completes at this edge

	assign done   = mov & moc;
	assign isLoad = (instrOpcode == OpLw);
	assign isMem  = isLoad | (instrOpcode == OpSw);

	// Opcode and funct to ALU operation
	always_comb begin
		aluOp = AluAdd;
		isNop = 1'b0;
		case (instrOpcode)
			OpRType: begin
				case (instrFunct)
					FnAddu:  aluOp = AluAdd;
					FnSubu:  aluOp = AluSub;
					FnAnd:   aluOp = AluAnd;
					FnOr:    aluOp = AluOr;
					FnXor:   aluOp = AluXor;
					FnNor:   aluOp = AluNor;
					FnSlt:   aluOp = AluSlt;
					FnSltu:  aluOp = AluSltu;
					FnSllv:  aluOp = AluSll;
					FnSrlv:  aluOp = AluSrl;
					FnSrav:  aluOp = AluSra;
					default: isNop = 1'b1;  // Includes the all-zero word
				endcase
			end
			OpAddiu, OpLw, OpSw: aluOp = AluAdd; // Address calc for LW/SW
			OpSlti:  aluOp = AluSlt;
			OpSltiu: aluOp = AluSltu;
			OpAndi:  aluOp = AluAnd;
			OpOri:   aluOp = AluOr;
			OpXori:  aluOp = AluXor;
			OpLui:   aluOp = AluLui;
			default: isNop = 1'b1;
		endcase
	end

	// Next state
	always_comb begin
		stateNext = state;
		case (state)
			StFetch:     if (done) stateNext = StDecode;
			StDecode:    stateNext = StExecute;
			StExecute: begin
				if (isNop)
					stateNext = StFetch;
				else if (isMem)
					stateNext = StMemAccess;
				else
					stateNext = StWriteBack;
			end
			StMemAccess: if (done) stateNext = isLoad ? StWriteBack : StFetch;
			StWriteBack: stateNext = StFetch;
			default:     stateNext = StFetch;
		endcase
	end

	// State and bus request flops
	always_ff @(posedge CLK) begin
		if (reset) begin
			state    <= StFetch;
			mov      <= 1'b0;
			memRead  <= 1'b0;
			memWrite <= 1'b0;
		end else begin
			state <= stateNext;
			if (done) begin  // Drop request after moc
				mov      <= 1'b0;
				memRead  <= 1'b0;
				memWrite <= 1'b0;
			end else if (!mov && state == StFetch) begin
				mov     <= 1'b1;
				memRead <= 1'b1;
			end else if (!mov && state == StMemAccess) begin
				mov      <= 1'b1;
				memRead  <= isLoad;
				memWrite <= ~isLoad;
			end
		end
	end

	// Control word per state
	always_comb begin
		ctrl           = '0;
		ctrl.aluOp     = aluOp;
		ctrl.aluSrcImm = (instrOpcode != OpRType);
		ctrl.regDstRd  = (instrOpcode == OpRType);
		ctrl.regInMem  = isLoad;
		ctrl.addrMar   = (state == StMemAccess);
		case (state)
			StFetch: begin
				ctrl.irLd = done;
				ctrl.pcLd = done;  // PC + 4
			end
			StDecode: ctrl.abLd = 1'b1;
			StExecute: begin
				ctrl.aluOutLd = 1'b1;
				ctrl.marLd    = isMem;
			end
			StMemAccess: ctrl.mdrLd = done & isLoad;
			StWriteBack: ctrl.regWrite = 1'b1;
			default: ;
		endcase
	end

endmodule

// File: src/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input  logic              CLK,
	input  logic              reset,
	input  mipsPkg::regAddr_t rdAddrA,
	input  mipsPkg::regAddr_t rdAddrB,
	input  mipsPkg::regAddr_t wrAddr,
	input  mipsPkg::word_t    wrData,
	input  logic              wrEn,
	output mipsPkg::word_t    rdDataA,
	output mipsPkg::word_t    rdDataB
);
	import mipsPkg::*;

	word_t regs [NUM_REGS];

	// Combinational read ports
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrAddr != '0) begin  // $zero stays zero
			regs[wrAddr] <= wrData;
		end
	end

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
	input  mipsPkg::aluOp_e op,
	input  mipsPkg::word_t  a,
	input  mipsPkg::word_t  b,
	output mipsPkg::word_t  y
);
	import mipsPkg::*;

	logic [SHAMT_W-1:0] shamt;
	logic               ltSigned;
	logic               ltUnsigned;

	assign shamt      = a[SHAMT_W-1:0];  // Variable shifts use rs low bits
	assign ltSigned   = ($signed(a) < $signed(b));
	assign ltUnsigned = (a < b);

	always_comb begin
		case (op)
			AluAdd:  y = a + b;   // Wraps mod 2^32
			AluSub:  y = a - b;
			AluAnd:  y = a & b;
			AluOr:   y = a | b;
			AluXor:  y = a ^ b;
			AluNor:  y = ~(a | b);
			AluSlt:  y = word_t'(ltSigned);
			AluSltu: y = word_t'(ltUnsigned);
			AluSll:  y = b << shamt;
			AluSrl:  y = b >> shamt;
			AluSra:  y = word_t'($signed(b) >>> shamt);
			AluLui:  y = b << 16;  // Immediate to upper half
			default: y = '0;
		endcase
	end

endmodule

// File: src/mipsPkg.sv
package mipsPkg;

	// Widths
	localparam int WORD_W     = 32;
	localparam int ADDR_W     = 9;          // 512-byte memory
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 2 ** REG_ADDR_W;
	localparam int SHAMT_W    = $clog2(WORD_W); // Variable shift amount bits

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [ADDR_W-1:0]     memAddr_t;
	typedef logic [REG_ADDR_W-1:0] regAddr_t;

	localparam memAddr_t RESET_PC    = '0;  // First fetch
	localparam memAddr_t INSTR_BYTES = ADDR_W'(4);

	// Primary opcodes, MIPS encodings
	typedef enum logic [5:0] {
		OpRType = 6'h00,
		OpAddiu = 6'h09,
		OpSlti  = 6'h0A,
		OpSltiu = 6'h0B,
		OpAndi  = 6'h0C,
		OpOri   = 6'h0D,
		OpXori  = 6'h0E,
		OpLui   = 6'h0F,
		OpLw    = 6'h23,
		OpSw    = 6'h2B
	} opcode_e;

	// R-type funct codes still supported
	typedef enum logic [5:0] {
		FnSllv = 6'h04,
		FnSrlv = 6'h06,
		FnSrav = 6'h07,
		FnAddu = 6'h21,
		FnSubu = 6'h23,
		FnAnd  = 6'h24,
		FnOr   = 6'h25,
		FnXor  = 6'h26,
		FnNor  = 6'h27,
		FnSlt  = 6'h2A,
		FnSltu = 6'h2B
	} funct_e;

	typedef enum logic [3:0] {
		AluAdd, AluSub, AluAnd, AluOr, AluXor, AluNor,
		AluSlt, AluSltu, AluSll, AluSrl, AluSra, AluLui
	} aluOp_e;

	typedef enum logic [2:0] {
		StFetch, StDecode, StExecute, StMemAccess, StWriteBack
	} state_e;

	// Control unit to datapath
	typedef struct packed {
		logic   irLd;
		logic   pcLd;
		logic   abLd;      // A and B from register file
		logic   aluOutLd;
		logic   marLd;
		logic   mdrLd;
		logic   regWrite;
		logic   regDstRd;  // rd instead of rt
		logic   regInMem;  // MDR instead of ALU result
		logic   aluSrcImm; // Immediate instead of B
		logic   addrMar;   // Memory address from MAR instead of PC
		aluOp_e aluOp;
	} ctrlWord_t;

	// Core to memory
	typedef struct packed {
		logic     mov;   // Request
		logic     read;
		logic     write;
		memAddr_t addr;
		word_t    wdata;
	} memReq_t;

	// Memory to core
	typedef struct packed {
		logic  moc;      // Completion, one cycle
		word_t rdata;
	} memRsp_t;

endpackage
